/* verilog/rn_pkg.sv */
// shared widths, counts and reset values for the rename subsystem, pulled in with rn_pkg::*
`default_nettype none

package rn_pkg;

   // physical register file
   // index width and entry count
   localparam int prf_aw = 6;
   localparam int n_prf = 64;

   // architectural (logical) registers
   localparam int lrf_aw = 5;
   localparam int n_lrf = 32;

   // rename slots per cycle
   localparam int iw = 2;

   // commit slots per cycle
   localparam int cw = 2;

   // free-list reset value
   // p0..p31 hold the reset mapping of x0..x31
   // so only the upper half starts out free
   localparam logic [n_prf-1:0] fl_rst_vec = {{(n_prf - n_lrf){1'b1}}, {n_lrf{1'b0}}};

   // flattened bus widths used on the rename ports
   // one field per slot, slot 0 in the low bits
   // iw and cw stay at 2 since the dependency stage is written for a pair

endpackage

`default_nettype wire

/* verilog/priority_encoder_gs.sv */
// lowest-set-bit encoder with group select, picks one free physical register per copy
`timescale 1ns/1ps
`default_nettype none

module priority_encoder_gs
   import rn_pkg::*;
(
   input  wire [n_prf-1:0]  din,
   output logic [prf_aw-1:0] dout,
   output logic              gs
);

   // scan from the top down
   // so the last hit written is the lowest set bit
   always_comb
      begin
         dout = '0;
         for (int i = n_prf - 1; i >= 0; i--)
            begin
               if (din[i])
                  dout = prf_aw'(i);
            end
      end

   // group select
   // any bit set means dout is a real index
   assign gs = |din;

   // when gs is low dout reads zero
   // callers must qualify it with gs

endmodule

`default_nettype wire

/* verilog/rn_fl.sv */
// speculative and architectural free lists, hands out two free registers and recycles at commit
`timescale 1ns/1ps
`default_nettype none

module rn_fl
   import rn_pkg::*;
(
   input  wire                   clk,
   input  wire                   rst,
   input  wire [iw-1:0]          pop,
   input  wire [iw-1:0]          lrd_we,
   input  wire                   rollback,
   input  wire [cw-1:0]          cmt_fire,
   input  wire [cw-1:0]          cmt_prd_we,
   input  wire [cw*prf_aw-1:0]   cmt_prd,
   input  wire [cw*prf_aw-1:0]   cmt_pfree,
   output logic [iw*prf_aw-1:0]  fl_prd,
   output logic [iw-1:0]         fl_gs
);

   // bit set means the physical register is free
   logic [n_prf-1:0]  fl_q;
   logic [n_prf-1:0]  afl_q;
   logic [n_prf-1:0]  fl_nxt;
   logic [n_prf-1:0]  afl_nxt;
   logic [n_prf-1:0]  fl_mask1;
   logic [prf_aw-1:0] prd0;
   logic [prf_aw-1:0] prd1;

   // slot 0 takes the lowest free register
   priority_encoder_gs u_penc0 (
      .din  (fl_q),
      .dout (prd0),
      .gs   (fl_gs[0])
   );

   // slot 1 skips slot 0's pick only if slot 0 wants a destination
   // otherwise both candidates match and nothing is wasted
   // pop cannot take part here
   // it is derived from the stall which already depends on gs
   assign fl_mask1 = lrd_we[0] ? (fl_q & ~(n_prf'(1) << prd0)) : fl_q;

   priority_encoder_gs u_penc1 (
      .din  (fl_mask1),
      .dout (prd1),
      .gs   (fl_gs[1])
   );

   assign fl_prd = {prd1, prd0};

   // speculative next state
   // allocate on rename fire then return pfree of committed entries
   always_comb
      begin
         fl_nxt = fl_q;
         for (int i = 0; i < iw; i++)
            begin
               if (pop[i] && lrd_we[i])
                  fl_nxt[fl_prd[i*prf_aw +: prf_aw]] = 1'b0;
            end
         for (int i = 0; i < cw; i++)
            begin
               if (cmt_fire[i] && cmt_prd_we[i])
                  fl_nxt[cmt_pfree[i*prf_aw +: prf_aw]] = 1'b1;
            end
      end

   // architectural next state
   // per slot in order, claim prd and then release pfree
   // keeps the case where slot 1 frees slot 0's register correct
   always_comb
      begin
         afl_nxt = afl_q;
         for (int i = 0; i < cw; i++)
            begin
               if (cmt_fire[i] && cmt_prd_we[i])
                  begin
                     afl_nxt[cmt_prd[i*prf_aw +: prf_aw]] = 1'b0;
                     afl_nxt[cmt_pfree[i*prf_aw +: prf_aw]] = 1'b1;
                  end
            end
      end

   // rollback loads the committed view as it was before this edge
   always_ff @(posedge clk)
      begin
         if (rst)
            begin
               fl_q  <= fl_rst_vec;
               afl_q <= fl_rst_vec;
            end
         else
            begin
               afl_q <= afl_nxt;
               fl_q  <= rollback ? afl_q : fl_nxt;
            end
      end

   // stall logic in rn_dep must keep pop off an empty list
   // and the ROB must never hand back a register twice
   for (genvar i = 0; i < iw; i++)
      begin : g_alloc_chk
         a_alloc_free: assert property (@(posedge clk) disable iff (rst)
            (pop[i] && lrd_we[i]) |-> fl_q[fl_prd[i*prf_aw +: prf_aw]])
            else $error("rn_fl: slot %0d allocated a busy register", i);
      end

   for (genvar i = 0; i < cw; i++)
      begin : g_free_chk
         a_free_busy: assert property (@(posedge clk) disable iff (rst)
            (cmt_fire[i] && cmt_prd_we[i]) |-> !fl_q[cmt_pfree[i*prf_aw +: prf_aw]])
            else $error("rn_fl: commit slot %0d freed a free register", i);
      end

endmodule

`default_nettype wire

/* verilog/rn_rat.sv */
// speculative and architectural register alias tables, read per slot and restored on rollback
`timescale 1ns/1ps
`default_nettype none

module rn_rat
   import rn_pkg::*;
(
   input  wire                   clk,
   input  wire                   rst,
   input  wire [iw-1:0]          we,
   input  wire [iw*lrf_aw-1:0]   lrd,
   input  wire [iw*lrf_aw-1:0]   lrs1,
   input  wire [iw*lrf_aw-1:0]   lrs2,
   input  wire [iw*prf_aw-1:0]   prd_new,
   input  wire                   rollback,
   input  wire [cw-1:0]          cmt_fire,
   input  wire [cw-1:0]          cmt_prd_we,
   input  wire [cw*lrf_aw-1:0]   cmt_lrd,
   input  wire [cw*prf_aw-1:0]   cmt_prd,
   output logic [iw*prf_aw-1:0]  rat_prs1,
   output logic [iw*prf_aw-1:0]  rat_prs2,
   output logic [iw*prf_aw-1:0]  rat_prd_old
);

   // logical to physical
   // smap runs ahead with rename, amap follows commit
   logic [prf_aw-1:0] smap [n_lrf];
   logic [prf_aw-1:0] amap [n_lrf];

   // reads see the table before this cycle's writes
   // slot 1 vs slot 0 forwarding is left to rn_dep
   always_comb
      begin
         for (int i = 0; i < iw; i++)
            begin
               rat_prs1[i*prf_aw +: prf_aw]    = smap[lrs1[i*lrf_aw +: lrf_aw]];
               rat_prs2[i*prf_aw +: prf_aw]    = smap[lrs2[i*lrf_aw +: lrf_aw]];
               rat_prd_old[i*prf_aw +: prf_aw] = smap[lrd[i*lrf_aw +: lrf_aw]];
            end
      end

   always_ff @(posedge clk)
      begin
         if (rst)
            begin
               // identity map, xN lives in pN
               for (int j = 0; j < n_lrf; j++)
                  begin
                     smap[j] <= prf_aw'(j);
                     amap[j] <= prf_aw'(j);
                  end
            end
         else
            begin
               // commit in slot order
               // a later slot to the same lrd overrides
               for (int i = 0; i < cw; i++)
                  begin
                     if (cmt_fire[i] && cmt_prd_we[i])
                        amap[cmt_lrd[i*lrf_aw +: lrf_aw]] <= cmt_prd[i*prf_aw +: prf_aw];
                  end
               // rollback wins over rename
               // copies amap as it stood before this edge
               if (rollback)
                  begin
                     for (int j = 0; j < n_lrf; j++)
                        smap[j] <= amap[j];
                  end
               else
                  begin
                     // slot 1 written last so it wins on the same lrd
                     for (int i = 0; i < iw; i++)
                        begin
                           if (we[i])
                              smap[lrd[i*lrf_aw +: lrf_aw]] <= prd_new[i*prf_aw +: prf_aw];
                        end
                  end
            end
      end

   // a write must carry a fresh register from the free list
   // never the one the lrd already maps to
   for (genvar i = 0; i < iw; i++)
      begin : g_we_chk
         a_we_fresh: assert property (@(posedge clk) disable iff (rst)
            we[i] |-> (prd_new[i*prf_aw +: prf_aw] != rat_prd_old[i*prf_aw +: prf_aw]))
            else $error("rn_rat: slot %0d writes without a new destination", i);
      end

   // the two slots of one group never share a new register
   a_we_distinct: assert property (@(posedge clk) disable iff (rst)
      (we[0] && we[1]) |-> (prd_new[0 +: prf_aw] != prd_new[prf_aw +: prf_aw]))
      else $error("rn_rat: both slots got the same new register");

endmodule

`default_nettype wire

/* verilog/rn_dep.sv */
// intra-group dependency stage, forwards slot 0 to slot 1 and forms the rename stall
`timescale 1ns/1ps
`default_nettype none

module rn_dep
   import rn_pkg::*;
(
   input  wire [iw-1:0]          rn_valid,
   input  wire [iw-1:0]          rn_lrd_we,
   input  wire [iw*lrf_aw-1:0]   rn_lrd,
   input  wire [iw*lrf_aw-1:0]   rn_lrs1,
   input  wire [iw*lrf_aw-1:0]   rn_lrs2,
   input  wire [iw*prf_aw-1:0]   fl_prd,
   input  wire [iw-1:0]          fl_gs,
   input  wire [iw*prf_aw-1:0]   rat_prs1,
   input  wire [iw*prf_aw-1:0]   rat_prs2,
   input  wire [iw*prf_aw-1:0]   rat_prd_old,
   output logic                  rn_stall,
   output logic [iw*prf_aw-1:0]  rn_prd,
   output logic [iw*prf_aw-1:0]  rn_prs1,
   output logic [iw*prf_aw-1:0]  rn_prs2,
   output logic [iw*prf_aw-1:0]  rn_pfree
);

   logic              alloc0;
   logic              alloc1;
   logic              gs1;
   logic [prf_aw-1:0] prd0;
   logic [prf_aw-1:0] prd1;
   logic              hit_rs1;
   logic              hit_rs2;
   logic              hit_rd;

   // a slot needs a register only if valid and writing
   assign alloc0 = rn_valid[0] & rn_lrd_we[0];
   assign alloc1 = rn_valid[1] & rn_lrd_we[1];

   // slot 1 uses the second pick only behind an allocating slot 0
   assign prd0 = fl_prd[0 +: prf_aw];
   assign prd1 = alloc0 ? fl_prd[prf_aw +: prf_aw] : prd0;
   assign gs1  = alloc0 ? fl_gs[1] : fl_gs[0];

   // whole group waits if either allocating slot finds nothing
   assign rn_stall = (alloc0 & ~fl_gs[0]) | (alloc1 & ~gs1);

   // slot 1 reads what slot 0 is about to write
   assign hit_rs1 = alloc0 && (rn_lrs1[lrf_aw +: lrf_aw] == rn_lrd[0 +: lrf_aw]);
   assign hit_rs2 = alloc0 && (rn_lrs2[lrf_aw +: lrf_aw] == rn_lrd[0 +: lrf_aw]);
   // both slots target one lrd
   // slot 1 then frees slot 0's new register at commit
   assign hit_rd  = alloc0 && (rn_lrd[lrf_aw +: lrf_aw] == rn_lrd[0 +: lrf_aw]);

   assign rn_prd   = {prd1, prd0};
   assign rn_prs1  = {hit_rs1 ? prd0 : rat_prs1[prf_aw +: prf_aw], rat_prs1[0 +: prf_aw]};
   assign rn_prs2  = {hit_rs2 ? prd0 : rat_prs2[prf_aw +: prf_aw], rat_prs2[0 +: prf_aw]};
   assign rn_pfree = {hit_rd ? prd0 : rat_prd_old[prf_aw +: prf_aw],
                      rat_prd_old[0 +: prf_aw]};

endmodule

`default_nettype wire

/* verilog/rn_top.sv */
// rename top level, joins the free list, the alias table and the dependency stage
`timescale 1ns/1ps
`default_nettype none

module rn_top
   import rn_pkg::*;
(
   input  wire                   clk,
   input  wire                   rst,
   // rename group
   input  wire [iw-1:0]          rn_valid,
   input  wire [iw-1:0]          rn_lrd_we,
   input  wire [iw*lrf_aw-1:0]   rn_lrd,
   input  wire [iw*lrf_aw-1:0]   rn_lrs1,
   input  wire [iw*lrf_aw-1:0]   rn_lrs2,
   // commit from the ROB
   input  wire [cw-1:0]          cmt_fire,
   input  wire [cw-1:0]          cmt_prd_we,
   input  wire [cw*lrf_aw-1:0]   cmt_lrd,
   input  wire [cw*prf_aw-1:0]   cmt_prd,
   input  wire [cw*prf_aw-1:0]   cmt_pfree,
   input  wire                   rollback,
   // rename results
   output logic                  rn_stall,
   output logic [iw*prf_aw-1:0]  rn_prd,
   output logic [iw*prf_aw-1:0]  rn_prs1,
   output logic [iw*prf_aw-1:0]  rn_prs2,
   output logic [iw*prf_aw-1:0]  rn_pfree
);

   logic [iw-1:0]        fire;
   logic [iw-1:0]        alloc;
   logic [iw-1:0]        rat_we;
   logic [iw*prf_aw-1:0] fl_prd;
   logic [iw-1:0]        fl_gs;
   logic [iw*prf_aw-1:0] rat_prs1;
   logic [iw*prf_aw-1:0] rat_prs2;
   logic [iw*prf_aw-1:0] rat_prd_old;

   // all valid slots go together or none
   assign fire   = rn_valid & {iw{~rn_stall}};
   // destination request per slot, independent of the stall
   assign alloc  = rn_valid & rn_lrd_we;
   assign rat_we = fire & rn_lrd_we;

   rn_fl u_fl (
      .clk        (clk),
      .rst        (rst),
      .pop        (fire),
      .lrd_we     (alloc),
      .rollback   (rollback),
      .cmt_fire   (cmt_fire),
      .cmt_prd_we (cmt_prd_we),
      .cmt_prd    (cmt_prd),
      .cmt_pfree  (cmt_pfree),
      .fl_prd     (fl_prd),
      .fl_gs      (fl_gs)
   );

   // table writes take the forwarded destinations from rn_dep
   rn_rat u_rat (
      .clk         (clk),
      .rst         (rst),
      .we          (rat_we),
      .lrd         (rn_lrd),
      .lrs1        (rn_lrs1),
      .lrs2        (rn_lrs2),
      .prd_new     (rn_prd),
      .rollback    (rollback),
      .cmt_fire    (cmt_fire),
      .cmt_prd_we  (cmt_prd_we),
      .cmt_lrd     (cmt_lrd),
      .cmt_prd     (cmt_prd),
      .rat_prs1    (rat_prs1),
      .rat_prs2    (rat_prs2),
      .rat_prd_old (rat_prd_old)
   );

   rn_dep u_dep (
      .rn_valid    (rn_valid),
      .rn_lrd_we   (rn_lrd_we),
      .rn_lrd      (rn_lrd),
      .rn_lrs1     (rn_lrs1),
      .rn_lrs2     (rn_lrs2),
      .fl_prd      (fl_prd),
      .fl_gs       (fl_gs),
      .rat_prs1    (rat_prs1),
      .rat_prs2    (rat_prs2),
      .rat_prd_old (rat_prd_old),
      .rn_stall    (rn_stall),
      .rn_prd      (rn_prd),
      .rn_prs1     (rn_prs1),
      .rn_prs2     (rn_prs2),
      .rn_pfree    (rn_pfree)
   );

endmodule

`default_nettype wire

/* dv/tb_rn_top.sv */
// top of the Verilator run that checks rn_top rename, stall, commit and rollback against a ROB model
`timescale 1ns/1ps
`default_nettype none

module tb_rn_top
   import rn_pkg::*;
();

   localparam int clk_half = 4;
   localparam int rst_cycles = 8;
   localparam int n_cycles = 3000;
   localparam int stall_limit = 64;
   localparam int drain_limit = 64;

   // one in-flight instruction
   // oldest sits at the queue front
   typedef struct packed {
      logic              we;
      logic [lrf_aw-1:0] lrd;
      logic [prf_aw-1:0] prd;
      logic [prf_aw-1:0] pfree;
   } rob_entry_t;

   logic                 clk;
   logic                 rst;
   logic [iw-1:0]        rn_valid;
   logic [iw-1:0]        rn_lrd_we;
   logic [iw*lrf_aw-1:0] rn_lrd;
   logic [iw*lrf_aw-1:0] rn_lrs1;
   logic [iw*lrf_aw-1:0] rn_lrs2;
   logic [cw-1:0]        cmt_fire;
   logic [cw-1:0]        cmt_prd_we;
   logic [cw*lrf_aw-1:0] cmt_lrd;
   logic [cw*prf_aw-1:0] cmt_prd;
   logic [cw*prf_aw-1:0] cmt_pfree;
   logic                 rollback;
   logic                 rn_stall;
   logic [iw*prf_aw-1:0] rn_prd;
   logic [iw*prf_aw-1:0] rn_prs1;
   logic [iw*prf_aw-1:0] rn_prs2;
   logic [iw*prf_aw-1:0] rn_pfree;

   // model state for the speculative and committed views
   logic [prf_aw-1:0] smap [n_lrf];
   logic [prf_aw-1:0] amap [n_lrf];
   logic [prf_aw-1:0] tmap [n_lrf];
   bit                sfree [n_prf];
   bit                afree [n_prf];
   bit                tfree [n_prf];
   rob_entry_t        rob [$];

   int seed = 32'hf3404da7;
   int stall_run;
   bit last_stall;

   rn_top u_dut (
      .clk        (clk),
      .rst        (rst),
      .rn_valid   (rn_valid),
      .rn_lrd_we  (rn_lrd_we),
      .rn_lrd     (rn_lrd),
      .rn_lrs1    (rn_lrs1),
      .rn_lrs2    (rn_lrs2),
      .cmt_fire   (cmt_fire),
      .cmt_prd_we (cmt_prd_we),
      .cmt_lrd    (cmt_lrd),
      .cmt_prd    (cmt_prd),
      .cmt_pfree  (cmt_pfree),
      .rollback   (rollback),
      .rn_stall   (rn_stall),
      .rn_prd     (rn_prd),
      .rn_prs1    (rn_prs1),
      .rn_prs2    (rn_prs2),
      .rn_pfree   (rn_pfree)
   );

   initial clk = 1'b0;
   always #clk_half clk = ~clk;

   // uniform pick in 0..n-1
   function automatic int rnd(input int n);
      int r;
      r = $random(seed);
      return (r & 32'h7fffffff) % n;
   endfunction

   function automatic int count_free();
      int n;
      n = 0;
      for (int i = 0; i < n_prf; i++)
         begin
            if (sfree[i])
               n++;
         end
      return n;
   endfunction

   // lowest index still free in the working copy
   // returns -1 if none
   function automatic int lowest_free();
      for (int i = 0; i < n_prf; i++)
         begin
            if (tfree[i])
               return i;
         end
      return -1;
   endfunction

   task automatic check_val(input string name, input int got, input int exp);
      if (got != exp)
         begin
            $display("[ERROR] t=%0t %s got %0d expected %0d", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1, "value mismatch on %s", name);
         end
   endtask

   task automatic fail_run(input string what);
      $display("t=%0t %s", $time, what);
      $display("Done: errors found");
      $fatal(1, "run aborted");
   endtask

   // identity map with the upper half of the register file free
   task automatic model_reset();
      for (int i = 0; i < n_lrf; i++)
         begin
            smap[i] = prf_aw'(i);
            amap[i] = prf_aw'(i);
         end
      for (int i = 0; i < n_prf; i++)
         begin
            sfree[i] = (i >= n_lrf);
            afree[i] = (i >= n_lrf);
         end
      rob.delete();
   endtask

   task automatic drive_group();
      for (int s = 0; s < iw; s++)
         begin
            rn_valid[s] = (rnd(4) != 0);
            rn_lrd_we[s] = (rnd(4) != 0);
            rn_lrd[s*lrf_aw +: lrf_aw] = lrf_aw'(rnd(n_lrf));
            rn_lrs1[s*lrf_aw +: lrf_aw] = lrf_aw'(rnd(n_lrf));
            rn_lrs2[s*lrf_aw +: lrf_aw] = lrf_aw'(rnd(n_lrf));
         end
      // steer slot 1 onto slot 0's destination now and then
      if (rnd(4) == 0)
         rn_lrs1[lrf_aw +: lrf_aw] = rn_lrd[0 +: lrf_aw];
      if (rnd(4) == 0)
         rn_lrs2[lrf_aw +: lrf_aw] = rn_lrd[0 +: lrf_aw];
      if (rnd(4) == 0)
         rn_lrd[lrf_aw +: lrf_aw] = rn_lrd[0 +: lrf_aw];
   endtask

   // retire up to n entries from the ROB head
   // commit slots stay contiguous from slot 0
   task automatic drive_commit(input int n);
      int k;
      rob_entry_t e;
      k = (n < rob.size()) ? n : rob.size();
      for (int c = 0; c < cw; c++)
         begin
            e = '0;
            if (c < k)
               e = rob[c];
            cmt_fire[c] = (c < k);
            cmt_prd_we[c] = e.we;
            cmt_lrd[c*lrf_aw +: lrf_aw] = e.lrd;
            cmt_prd[c*prf_aw +: prf_aw] = e.prd;
            cmt_pfree[c*prf_aw +: prf_aw] = e.pfree;
         end
   endtask

   // compare this cycle's outputs, then advance the model to the next edge
   task automatic check_and_update();
      int nfree;
      int nreq;
      int p;
      logic exp_stall;
      logic [lrf_aw-1:0] lrd;
      logic [lrf_aw-1:0] ls1;
      logic [lrf_aw-1:0] ls2;
      rob_entry_t e;
      nfree = count_free();
      nreq = 0;
      for (int s = 0; s < iw; s++)
         begin
            if (rn_valid[s] && rn_lrd_we[s])
               nreq++;
         end
      exp_stall = (nfree < nreq);
      check_val("rn_stall", int'(rn_stall), int'(exp_stall));
      last_stall = exp_stall;
      tmap = smap;
      tfree = sfree;
      // slots in program order
      // each one sees the older slot's write
      if (!exp_stall)
         begin
            for (int s = 0; s < iw; s++)
               begin
                  if (rn_valid[s])
                     begin
                        lrd = rn_lrd[s*lrf_aw +: lrf_aw];
                        ls1 = rn_lrs1[s*lrf_aw +: lrf_aw];
                        ls2 = rn_lrs2[s*lrf_aw +: lrf_aw];
                        check_val($sformatf("rn_prs1[%0d]", s),
                                  int'(rn_prs1[s*prf_aw +: prf_aw]), int'(tmap[ls1]));
                        check_val($sformatf("rn_prs2[%0d]", s),
                                  int'(rn_prs2[s*prf_aw +: prf_aw]), int'(tmap[ls2]));
                        e = '0;
                        e.we = rn_lrd_we[s];
                        e.lrd = lrd;
                        if (rn_lrd_we[s])
                           begin
                              p = lowest_free();
                              check_val($sformatf("rn_prd[%0d]", s),
                                        int'(rn_prd[s*prf_aw +: prf_aw]), p);
                              check_val($sformatf("rn_pfree[%0d]", s),
                                        int'(rn_pfree[s*prf_aw +: prf_aw]), int'(tmap[lrd]));
                              e.prd = prf_aw'(p);
                              e.pfree = tmap[lrd];
                              tmap[lrd] = prf_aw'(p);
                              tfree[p] = 1'b0;
                           end
                        rob.push_back(e);
                     end
               end
         end
      // retire from the head and return the old mapping to the pool
      for (int c = 0; c < cw; c++)
         begin
            if (cmt_fire[c])
               begin
                  e = rob.pop_front();
                  if (e.we)
                     begin
                        amap[e.lrd] = e.prd;
                        afree[e.prd] = 1'b0;
                        afree[e.pfree] = 1'b1;
                        tfree[e.pfree] = 1'b1;
                     end
               end
         end
      smap = tmap;
      sfree = tfree;
      // squash everything in flight
      if (rollback)
         begin
            smap = amap;
            sfree = afree;
            rob.delete();
         end
   endtask

   initial
      begin
         int cyc;
         int w;
         bit withhold;
         rst = 1'b1;
         rollback = 1'b0;
         rn_valid = '0;
         rn_lrd_we = '0;
         rn_lrd = '0;
         rn_lrs1 = '0;
         rn_lrs2 = '0;
         cmt_fire = '0;
         cmt_prd_we = '0;
         cmt_lrd = '0;
         cmt_prd = '0;
         cmt_pfree = '0;
         stall_run = 0;
         last_stall = 1'b0;
         model_reset();
         for (int i = 0; i < rst_cycles; i++)
            @(posedge clk);
         #1;
         rst = 1'b0;
         for (cyc = 0; cyc < n_cycles; cyc++)
            begin
               // every other window starves commit so the list runs dry
               withhold = ((cyc / 256) % 2 == 1) && (stall_run < 8);
               if (rnd(128) == 0)
                  begin
                     rollback = 1'b1;
                     rn_valid = '0;
                     drive_commit(0);
                  end
               else
                  begin
                     rollback = 1'b0;
                     // a stalled group stays on the inputs
                     if (!last_stall)
                        drive_group();
                     drive_commit(withhold ? 0 : rnd(cw + 1));
                  end
               #5;
               check_and_update();
               stall_run = last_stall ? stall_run + 1 : 0;
               if (stall_run > stall_limit)
                  fail_run("rename stayed stalled although commits were freeing registers");
               @(posedge clk);
               #1;
            end
         // drain the ROB with rename idle
         rollback = 1'b0;
         rn_valid = '0;
         for (w = 0; w < drain_limit && rob.size() > 0; w++)
            begin
               drive_commit(cw);
               #5;
               check_and_update();
               @(posedge clk);
               #1;
            end
         if (rob.size() != 0)
            fail_run("the ROB did not drain before its timeout");
         $display("Done: no errors");
         $finish;
      end

endmodule

`default_nettype wire

/* verilog.f */
verilog/rn_pkg.sv
verilog/priority_encoder_gs.sv
verilog/rn_fl.sv
verilog/rn_rat.sv
verilog/rn_dep.sv
verilog/rn_top.sv
dv/tb_rn_top.sv

/* run_sim.sh */
#!/bin/sh
# build the rename testbench with Verilator, run it, and pass only on the pass message in the log

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_rn_top -Mdir obj_dir -f verilog.f \
   > "$build_log" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
   cat "$build_log"
   echo "build failed with status $build_status"
   exit 1
fi

./obj_dir/Vtb_rn_top > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q -x "Done: no errors" "$sim_log"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi
